// ==== pipe_pkg.sv ====
package pipe_pkg;

    // hold flag driven by exu into both pipe stages
    localparam int HOLD_W = 2;
    localparam logic [HOLD_W-1:0] HOLD_NONE  = 2'd0;  // normal flow
    localparam logic [HOLD_W-1:0] HOLD_FLUSH = 2'd1;  // both pipe regs take a bubble
    localparam logic [HOLD_W-1:0] HOLD_STALL = 2'd2;  // both pipe regs keep contents

    // decode info bus, fields listed from the low end
    localparam int DECINFO_W     = 6;
    localparam int DI_ALU_OP_LSB = 0;  // alu op, 3 bits
    localparam int DI_USE_IMM    = 3;  // operand b is the immediate
    localparam int DI_IS_BRANCH  = 4;  // beq or bne
    localparam int DI_BRANCH_NE  = 5;  // set for bne

    // bubble and reset values
    localparam logic [31:0] INST_NOP  = 32'h0000_0013;  // addi x0,x0,0
    localparam logic [31:0] ZERO_WORD = 32'h0000_0000;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b011_0011;  // register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;  // register-immediate
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

    // funct3
    localparam logic [2:0] F3_ADD = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b010_0000;  // sub with funct3 add

    // alu operation codes carried in the decode info bus
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;  // signed compare

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef struct packed {
        logic       imm_12;  // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;  // sits where rd[0] would be
        logic [6:0] opcode;
    } btype_t;

    // one word, three views
    typedef union packed {
        rtype_t rtype;
        itype_t itype;
        btype_t btype;
    } inst_u;

endpackage

// ==== ifu_if_pipe.sv ====
`timescale 1ns/100ps

module ifu_if_pipe (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic [31:0]                 inst_i,        // offered instruction
    input  logic [31:0]                 inst_addr_i,   // its address
    input  logic                        inst_valid_i,
    input  logic [pipe_pkg::HOLD_W-1:0] hold_flag_i,   // from exu
    output logic                        inst_ready_o,
    output logic [31:0]                 inst_o,        // if/id instruction
    output logic [31:0]                 inst_addr_o    // if/id address
);

    import pipe_pkg::*;

    logic accept;  // transfer on this edge

    // no transfer while flushing or stalled
    assign inst_ready_o = (hold_flag_i == HOLD_NONE);
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_o      <= INST_NOP;
            inst_addr_o <= ZERO_WORD;
        end else if (hold_flag_i == HOLD_STALL) begin
            inst_o      <= inst_o;       // freeze
            inst_addr_o <= inst_addr_o;
        end else if (accept) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
        end else begin
            inst_o      <= INST_NOP;     // idle source or flush
            inst_addr_o <= ZERO_WORD;
        end
    end

endmodule

// ==== idu.sv ====
`timescale 1ns/100ps

module idu #(
    parameter int REG_ADDR_W = 5
) (
    input  logic [31:0]                    inst_i,
    output logic                           reg_we_o,        // rd write enable
    output logic [REG_ADDR_W-1:0]          reg_waddr_o,     // rd
    output logic [REG_ADDR_W-1:0]          reg1_raddr_o,    // rs1
    output logic [REG_ADDR_W-1:0]          reg2_raddr_o,    // rs2
    output logic [31:0]                    dec_imm_o,       // sign-extended immediate
    output logic [pipe_pkg::DECINFO_W-1:0] dec_info_bus_o
);

    import pipe_pkg::*;
    import isa_pkg::*;

    inst_u       inst;
    logic [31:0] imm_i_ext;  // i-type immediate
    logic [31:0] imm_b_ext;  // branch offset
    logic [2:0]  alu_op;
    logic        supported;  // encoding is in the subset
    logic        use_imm;
    logic        is_branch;
    logic        uses_rs2;

    assign inst      = inst_i;
    assign imm_i_ext = {{20{inst.itype.imm[11]}}, inst.itype.imm};
    assign imm_b_ext = {{20{inst.btype.imm_12}}, inst.btype.imm_11, inst.btype.imm_10_5,
                        inst.btype.imm_4_1, 1'b0};

    always_comb begin
        supported = 1'b0;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        uses_rs2  = 1'b0;
        case (inst.rtype.opcode)
            OPC_OP: begin
                uses_rs2  = 1'b1;
                supported = (inst.rtype.funct7 == 7'd0);  // plain r-type ops
                case (inst.rtype.funct3)
                    F3_ADD: begin
                        supported = supported || (inst.rtype.funct7 == F7_SUB);
                        alu_op    = (inst.rtype.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    end
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: supported = 1'b0;  // shifts, sltu
                endcase
            end
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                supported = 1'b1;
                case (inst.itype.funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: supported = 1'b0;  // slti, shifts
                endcase
            end
            OPC_BRANCH: begin
                is_branch = 1'b1;
                uses_rs2  = 1'b1;
                supported = (inst.btype.funct3 == F3_BEQ) || (inst.btype.funct3 == F3_BNE);
            end
            default: supported = 1'b0;
        endcase
    end

    // branches and unsupported words point rd at x0, so one compare covers all three
    assign reg_waddr_o  = (supported && !is_branch) ? inst.rtype.rd[REG_ADDR_W-1:0] : '0;
    assign reg_we_o     = (reg_waddr_o != '0);
    assign reg1_raddr_o = supported ? inst.rtype.rs1[REG_ADDR_W-1:0] : '0;
    assign reg2_raddr_o = (supported && uses_rs2) ? inst.rtype.rs2[REG_ADDR_W-1:0] : '0;

    assign dec_imm_o = !supported ? ZERO_WORD :
                       is_branch  ? imm_b_ext :
                       use_imm    ? imm_i_ext : ZERO_WORD;

    always_comb begin
        dec_info_bus_o = '0;  // bubble
        if (supported) begin
            dec_info_bus_o[DI_ALU_OP_LSB +: 3] = alu_op;
            dec_info_bus_o[DI_USE_IMM]         = use_imm;
            dec_info_bus_o[DI_IS_BRANCH]       = is_branch;
            dec_info_bus_o[DI_BRANCH_NE]       = is_branch && (inst.btype.funct3 == F3_BNE);
        end
    end

endmodule

// ==== idu_id_pipe.sv ====
`timescale 1ns/100ps

module idu_id_pipe #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [31:0]                    inst_addr_i,
    input  logic                           reg_we_i,
    input  logic [REG_ADDR_W-1:0]          reg_waddr_i,
    input  logic [REG_ADDR_W-1:0]          reg1_raddr_i,
    input  logic [REG_ADDR_W-1:0]          reg2_raddr_i,
    input  logic [31:0]                    dec_imm_i,
    input  logic [pipe_pkg::DECINFO_W-1:0] dec_info_bus_i,
    input  logic [pipe_pkg::HOLD_W-1:0]    hold_flag_i,
    output logic [31:0]                    inst_addr_o,
    output logic                           reg_we_o,
    output logic [REG_ADDR_W-1:0]          reg_waddr_o,
    output logic [REG_ADDR_W-1:0]          reg1_raddr_o,   // addresses, exu reads the file
    output logic [REG_ADDR_W-1:0]          reg2_raddr_o,
    output logic [31:0]                    dec_imm_o,
    output logic [pipe_pkg::DECINFO_W-1:0] dec_info_bus_o
);

    import pipe_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i || hold_flag_i == HOLD_FLUSH) begin
            inst_addr_o    <= ZERO_WORD;  // bubble
            reg_we_o       <= 1'b0;
            reg_waddr_o    <= '0;
            reg1_raddr_o   <= '0;
            reg2_raddr_o   <= '0;
            dec_imm_o      <= ZERO_WORD;
            dec_info_bus_o <= '0;
        end else if (hold_flag_i != HOLD_STALL) begin
            inst_addr_o    <= inst_addr_i;
            reg_we_o       <= reg_we_i;
            reg_waddr_o    <= reg_waddr_i;
            reg1_raddr_o   <= reg1_raddr_i;
            reg2_raddr_o   <= reg2_raddr_i;
            dec_imm_o      <= dec_imm_i;
            dec_info_bus_o <= dec_info_bus_i;
        end
        // stall keeps every field
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [31:0]           wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [31:0]           rdata1_o,
    output logic [31:0]           rdata2_o
);

    import pipe_pkg::*;

    logic [31:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;  // x0 never written
        end
    end

    // combinational reads, x0 hardwired
    assign rdata1_o = (raddr1_i == '0) ? ZERO_WORD : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? ZERO_WORD : regs[raddr2_i];

endmodule

// ==== exu.sv ====
`timescale 1ns/100ps

module exu #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic [31:0]                    inst_addr_i,
    input  logic                           reg_we_i,
    input  logic [REG_ADDR_W-1:0]          reg_waddr_i,
    input  logic [REG_ADDR_W-1:0]          reg1_raddr_i,
    input  logic [REG_ADDR_W-1:0]          reg2_raddr_i,
    input  logic [31:0]                    dec_imm_i,
    input  logic [pipe_pkg::DECINFO_W-1:0] dec_info_bus_i,
    input  logic [31:0]                    rdata1_i,        // rs1 value
    input  logic [31:0]                    rdata2_i,        // rs2 value
    input  logic                           wb_ready_i,
    output logic [REG_ADDR_W-1:0]          raddr1_o,
    output logic [REG_ADDR_W-1:0]          raddr2_o,
    output logic                           rf_we_o,
    output logic [REG_ADDR_W-1:0]          rf_waddr_o,
    output logic [31:0]                    rf_wdata_o,
    output logic [pipe_pkg::HOLD_W-1:0]    hold_flag_o,
    output logic                           redirect_o,
    output logic [31:0]                    redirect_addr_o, // branch target
    output logic                           wb_valid_o,
    output logic [31:0]                    wb_addr_o,       // retired instruction address
    output logic [REG_ADDR_W-1:0]          wb_rd_o,
    output logic [31:0]                    wb_data_o
);

    import pipe_pkg::*;
    import isa_pkg::*;

    logic [2:0]  alu_op;
    logic [31:0] op_b;       // rs2 or immediate
    logic [31:0] alu_res;
    logic        is_branch;
    logic        branch_ne;
    logic        taken;
    logic        stall;      // result waiting on the sink

    assign alu_op    = dec_info_bus_i[DI_ALU_OP_LSB +: 3];
    assign is_branch = dec_info_bus_i[DI_IS_BRANCH];
    assign branch_ne = dec_info_bus_i[DI_BRANCH_NE];
    assign op_b      = dec_info_bus_i[DI_USE_IMM] ? dec_imm_i : rdata2_i;

    assign raddr1_o = reg1_raddr_i;
    assign raddr2_o = reg2_raddr_i;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rdata1_i - op_b;
            ALU_AND: alu_res = rdata1_i & op_b;
            ALU_OR:  alu_res = rdata1_i | op_b;
            ALU_XOR: alu_res = rdata1_i ^ op_b;
            ALU_SLT: alu_res = {31'd0, $signed(rdata1_i) < $signed(op_b)};
            default: alu_res = rdata1_i + op_b;  // add, addi
        endcase
    end

    // beq or bne on the raw register values
    assign taken = is_branch && ((rdata1_i == rdata2_i) != branch_ne);
    assign stall = wb_valid_o && !wb_ready_i;

    assign hold_flag_o     = stall ? HOLD_STALL :
                             taken ? HOLD_FLUSH : HOLD_NONE;
    assign redirect_o      = taken && !stall;
    assign redirect_addr_o = inst_addr_i + dec_imm_i;

    // file write lands on the edge that loads the wb register
    assign rf_we_o    = reg_we_i && !stall;
    assign rf_waddr_o = reg_waddr_i;
    assign rf_wdata_o = alu_res;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else if (!stall) begin
            wb_valid_o <= reg_we_i;  // branches and bubbles do not retire
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_addr_o <= inst_addr_i;
            wb_rd_o   <= reg_waddr_i;
            wb_data_o <= alu_res;
        end
    end

endmodule

// ==== core_top.sv ====
`timescale 1ns/100ps

module core_top #(
    parameter int REG_ADDR_W = 5  // 4 for an rv32e-sized file
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [31:0]           inst_i,
    input  logic [31:0]           inst_addr_i,
    input  logic                  inst_valid_i,
    input  logic                  wb_ready_i,
    output logic                  inst_ready_o,
    output logic                  redirect_o,
    output logic [31:0]           redirect_addr_o,
    output logic                  wb_valid_o,
    output logic [31:0]           wb_addr_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [31:0]           wb_data_o
);

    import pipe_pkg::*;

    logic [HOLD_W-1:0]     hold_flag;
    logic [31:0]           if_inst;         // if/id
    logic [31:0]           if_inst_addr;
    logic                  id_reg_we;       // decoder outputs
    logic [REG_ADDR_W-1:0] id_reg_waddr;
    logic [REG_ADDR_W-1:0] id_reg1_raddr;
    logic [REG_ADDR_W-1:0] id_reg2_raddr;
    logic [31:0]           id_imm;
    logic [DECINFO_W-1:0]  id_dec_info;
    logic [31:0]           ex_inst_addr;    // id/ex
    logic                  ex_reg_we;
    logic [REG_ADDR_W-1:0] ex_reg_waddr;
    logic [REG_ADDR_W-1:0] ex_reg1_raddr;
    logic [REG_ADDR_W-1:0] ex_reg2_raddr;
    logic [31:0]           ex_imm;
    logic [DECINFO_W-1:0]  ex_dec_info;
    logic [REG_ADDR_W-1:0] rf_raddr1;       // register file side
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [31:0]           rf_rdata1;
    logic [31:0]           rf_rdata2;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [31:0]           rf_wdata;

    ifu_if_pipe i_ifu_if_pipe (
        .clk(clk), .reset_i(reset_i), .inst_i(inst_i), .inst_addr_i(inst_addr_i),
        .inst_valid_i(inst_valid_i), .hold_flag_i(hold_flag), .inst_ready_o(inst_ready_o),
        .inst_o(if_inst), .inst_addr_o(if_inst_addr)
    );

    idu #(.REG_ADDR_W(REG_ADDR_W)) i_idu (
        .inst_i(if_inst), .reg_we_o(id_reg_we), .reg_waddr_o(id_reg_waddr),
        .reg1_raddr_o(id_reg1_raddr), .reg2_raddr_o(id_reg2_raddr),
        .dec_imm_o(id_imm), .dec_info_bus_o(id_dec_info)
    );

    idu_id_pipe #(.REG_ADDR_W(REG_ADDR_W)) i_idu_id_pipe (
        .clk(clk), .reset_i(reset_i), .inst_addr_i(if_inst_addr), .reg_we_i(id_reg_we),
        .reg_waddr_i(id_reg_waddr), .reg1_raddr_i(id_reg1_raddr),
        .reg2_raddr_i(id_reg2_raddr), .dec_imm_i(id_imm), .dec_info_bus_i(id_dec_info),
        .hold_flag_i(hold_flag), .inst_addr_o(ex_inst_addr), .reg_we_o(ex_reg_we),
        .reg_waddr_o(ex_reg_waddr), .reg1_raddr_o(ex_reg1_raddr),
        .reg2_raddr_o(ex_reg2_raddr), .dec_imm_o(ex_imm), .dec_info_bus_o(ex_dec_info)
    );

    regfile #(.REG_ADDR_W(REG_ADDR_W)) i_regfile (
        .clk(clk), .reset_i(reset_i), .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2), .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    exu #(.REG_ADDR_W(REG_ADDR_W)) i_exu (
        .clk(clk), .reset_i(reset_i), .inst_addr_i(ex_inst_addr), .reg_we_i(ex_reg_we),
        .reg_waddr_i(ex_reg_waddr), .reg1_raddr_i(ex_reg1_raddr),
        .reg2_raddr_i(ex_reg2_raddr), .dec_imm_i(ex_imm), .dec_info_bus_i(ex_dec_info),
        .rdata1_i(rf_rdata1), .rdata2_i(rf_rdata2), .wb_ready_i(wb_ready_i),
        .raddr1_o(rf_raddr1), .raddr2_o(rf_raddr2), .rf_we_o(rf_we), .rf_waddr_o(rf_waddr),
        .rf_wdata_o(rf_wdata), .hold_flag_o(hold_flag), .redirect_o(redirect_o),
        .redirect_addr_o(redirect_addr_o), .wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o),
        .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

endmodule

// ==== tb_core_top.sv ====
`timescale 1ns/100ps

module tb_core_top;

    import isa_pkg::*;

    localparam int PROG_LEN   = 30;
    localparam int PASSES     = 2;                    // sink always ready, then random
    localparam int MAX_CYCLES = 20 * PROG_LEN + 100;

    logic        clk;
    logic        reset_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_valid_i;
    logic        wb_ready_i;
    logic        inst_ready_o;
    logic        redirect_o;
    logic [31:0] redirect_addr_o;
    logic        wb_valid_o;
    logic [31:0] wb_addr_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    // program table, indexed by address/4
    logic [31:0] prog_inst [PROG_LEN];
    logic        prog_ret  [PROG_LEN];                // retires
    logic [4:0]  prog_rd   [PROG_LEN];
    logic [31:0] prog_data [PROG_LEN];
    int          prog_tgt  [PROG_LEN];                // taken branch target index, else -1
    int          accept_edge [PROG_LEN];
    int          exp_q [$];                           // table indices in retire order
    int          exp_redir [$];                       // redirect targets in order
    int          n_loaded;
    int          n_per_pass;
    int          seed;
    int          cycle;
    int          pc;                                  // fetch index
    int          pass;
    int          sb_pos;                              // retirements checked
    int          redir_pos;
    int          drain;

    core_top #(.REG_ADDR_W(5)) i_core_top (
        .clk(clk), .reset_i(reset_i), .inst_i(inst_i), .inst_addr_i(inst_addr_i),
        .inst_valid_i(inst_valid_i), .wb_ready_i(wb_ready_i), .inst_ready_o(inst_ready_o),
        .redirect_o(redirect_o), .redirect_addr_o(redirect_addr_o), .wb_valid_o(wb_valid_o),
        .wb_addr_o(wb_addr_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        inst_u w;
        w.rtype = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        inst_u w;
        w.itype = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
        return w;
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        inst_u w;
        w.btype = '{imm_12: off[12], imm_10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
                    imm_4_1: off[4:1], imm_11: off[11], opcode: OPC_BRANCH};
        return w;
    endfunction

    task automatic add_step(input logic [31:0] inst, input logic ret, input logic [4:0] rd,
                            input logic [31:0] data, input int tgt);
        prog_inst[n_loaded] = inst;
        prog_ret[n_loaded]  = ret;
        prog_rd[n_loaded]   = rd;
        prog_data[n_loaded] = data;
        prog_tgt[n_loaded]  = tgt;
        n_loaded++;
    endtask

    task automatic load_program();
        n_loaded = 0;
        add_step(itype_word(12'd5, 0, F3_ADD, 1), 1, 1, 32'h0000_0005, -1);
        add_step(itype_word(12'hffd, 0, F3_ADD, 2), 1, 2, 32'hffff_fffd, -1);   // -3
        add_step(rtype_word(0, 2, 1, F3_ADD, 3), 1, 3, 32'h0000_0002, -1);
        add_step(rtype_word(F7_SUB, 1, 2, F3_ADD, 4), 1, 4, 32'hffff_fff8, -1); // -8
        add_step(rtype_word(0, 4, 2, F3_AND, 5), 1, 5, 32'hffff_fff8, -1);
        add_step(rtype_word(0, 4, 1, F3_OR, 6), 1, 6, 32'hffff_fffd, -1);
        add_step(rtype_word(0, 2, 1, F3_XOR, 7), 1, 7, 32'hffff_fff8, -1);
        add_step(rtype_word(0, 1, 2, F3_SLT, 8), 1, 8, 32'h0000_0001, -1);      // -3 < 5
        add_step(rtype_word(0, 4, 1, F3_SLT, 9), 1, 9, 32'h0000_0000, -1);      // 5 < -8
        add_step(itype_word(12'h0f0, 2, F3_AND, 10), 1, 10, 32'h0000_00f0, -1);
        add_step(itype_word(12'h700, 1, F3_OR, 11), 1, 11, 32'h0000_0705, -1);
        add_step(itype_word(12'hfff, 1, F3_XOR, 12), 1, 12, 32'hffff_fffa, -1);
        add_step(itype_word(12'd7, 1, F3_ADD, 0), 0, 0, 32'h0, -1);             // rd is x0
        add_step(rtype_word(0, 1, 0, F3_ADD, 13), 1, 13, 32'h0000_0005, -1);    // x0 reads 0
        add_step(rtype_word(0, 1, 1, 3'b001, 14), 0, 0, 32'h0, -1);             // sll, no support
        add_step(itype_word(12'd1, 13, F3_ADD, 14), 1, 14, 32'h0000_0006, -1);
        add_step(itype_word(12'd1, 14, F3_ADD, 14), 1, 14, 32'h0000_0007, -1);
        add_step(branch_word(13'd12, 13, 1, F3_BEQ), 0, 0, 32'h0, 20);          // taken
        add_step(itype_word(12'd99, 0, F3_ADD, 15), 0, 0, 32'h0, -1);           // skipped
        add_step(itype_word(12'd99, 0, F3_ADD, 16), 0, 0, 32'h0, -1);           // skipped
        add_step(branch_word(13'd8, 13, 1, F3_BNE), 0, 0, 32'h0, -1);           // not taken
        add_step(rtype_word(0, 1, 14, F3_ADD, 15), 1, 15, 32'h0000_000c, -1);
        add_step(branch_word(13'd12, 2, 1, F3_BNE), 0, 0, 32'h0, 25);           // taken
        add_step(itype_word(12'd1, 0, F3_ADD, 15), 0, 0, 32'h0, -1);            // skipped
        add_step(itype_word(12'd1, 0, F3_XOR, 16), 0, 0, 32'h0, -1);            // skipped
        add_step(branch_word(13'd8, 2, 1, F3_BEQ), 0, 0, 32'h0, -1);            // not taken
        add_step(rtype_word(F7_SUB, 14, 15, F3_ADD, 16), 1, 16, 32'h0000_0005, -1);
        add_step(rtype_word(0, 2, 4, F3_SLT, 17), 1, 17, 32'h0000_0001, -1);    // -8 < -3
        add_step(itype_word(12'hffe, 17, F3_ADD, 18), 1, 18, 32'hffff_ffff, -1);
        add_step(itype_word(12'd0, 18, F3_ADD, 19), 1, 19, 32'hffff_ffff, -1);
    endtask

    // program order walk, following taken branches
    task automatic build_expected();
        int idx;
        for (int p = 0; p < PASSES; p++) begin
            idx = 0;
            while (idx < PROG_LEN) begin
                if (prog_ret[idx]) exp_q.push_back(idx);
                if (prog_tgt[idx] >= 0) begin
                    exp_redir.push_back(prog_tgt[idx] * 4);
                    idx = prog_tgt[idx];
                end else begin
                    idx++;
                end
            end
            if (p == 0) n_per_pass = exp_q.size();
        end
    endtask

    task automatic drive_fetch();
        if (pass < PASSES) begin
            inst_valid_i = 1'b1;
            inst_i       = prog_inst[pc];
            inst_addr_i  = pc * 4;
        end else begin
            inst_valid_i = 1'b0;  // program done
            inst_i       = '0;
            inst_addr_i  = '0;
        end
    endtask

    task automatic stop_on_error();
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        logic        fire;
        logic        redir;
        logic [31:0] redir_addr;
        logic        held;
        logic [31:0] held_addr;
        logic [4:0]  held_rd;
        logic [31:0] held_data;
        int          idx;
        int          r;
        seed = 62;
        reset_i = 1'b1;
        inst_i = '0;
        inst_addr_i = '0;
        inst_valid_i = 1'b0;
        wb_ready_i = 1'b1;
        {cycle, pc, pass, sb_pos, redir_pos, drain} = '0;
        held = 1'b0;
        load_program();
        build_expected();
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        assert (!wb_valid_o && !redirect_o && inst_ready_o) else begin
            $display("Fail at %0t: reset state wb_valid %b redirect %b ready %b", $time,
                     wb_valid_o, redirect_o, inst_ready_o);
            stop_on_error();
        end
        drive_fetch();
        while (sb_pos < exp_q.size() || drain < 5) begin
            @(negedge clk);  // outputs settled here
            fire       = inst_valid_i && inst_ready_o;
            redir      = redirect_o;
            redir_addr = redirect_addr_o;
            if (fire) accept_edge[pc] = cycle + 1;
            if (held) begin
                assert (wb_valid_o && wb_addr_o == held_addr && wb_rd_o == held_rd &&
                        wb_data_o == held_data) else begin
                    $display("Fail at %0t: writeback changed while sink not ready", $time);
                    stop_on_error();
                end
            end
            if (redir) begin
                assert (redir_pos < exp_redir.size() && redir_addr == exp_redir[redir_pos])
                else begin
                    $display("Fail at %0t: unexpected redirect to %h", $time, redir_addr);
                    stop_on_error();
                end
                redir_pos++;
            end
            if (wb_valid_o && wb_ready_i) begin
                assert (sb_pos < exp_q.size()) else begin
                    $display("Fail at %0t: extra writeback addr %h", $time, wb_addr_o);
                    stop_on_error();
                end
                idx = exp_q[sb_pos];
                assert (wb_addr_o == idx * 4 && wb_rd_o == prog_rd[idx] &&
                        wb_data_o == prog_data[idx]) else begin
                    $display("Fail at %0t: got addr %h rd %0d data %h, want %h %0d %h",
                             $time, wb_addr_o, wb_rd_o, wb_data_o, idx * 4, prog_rd[idx],
                             prog_data[idx]);
                    stop_on_error();
                end
                if (sb_pos < n_per_pass) begin  // sink always ready in first pass
                    assert (cycle == accept_edge[idx] + 2) else begin
                        $display("Fail at %0t: addr %h retired at edge %0d, accepted at %0d",
                                 $time, wb_addr_o, cycle, accept_edge[idx]);
                        stop_on_error();
                    end
                end
                sb_pos++;
            end
            held      = wb_valid_o && !wb_ready_i;
            held_addr = wb_addr_o;
            held_rd   = wb_rd_o;
            held_data = wb_data_o;
            @(posedge clk);
            cycle++;
            if (cycle >= MAX_CYCLES) begin
                $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                stop_on_error();
            end
            if (sb_pos == exp_q.size()) drain++;
            #2;
            if (redir) begin
                pc = redir_addr >> 2;  // source follows the branch
            end else if (fire) begin
                pc++;
                if (pc == PROG_LEN) begin
                    pc = 0;
                    pass++;
                end
            end
            drive_fetch();
            if (sb_pos >= n_per_pass) begin
                r = $random(seed);
                wb_ready_i = r[0];
            end
        end
        assert (redir_pos == exp_redir.size()) else begin
            $display("Fail at %0t: %0d redirects seen, %0d expected", $time, redir_pos,
                     exp_redir.size());
            stop_on_error();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
pipe_pkg.sv
isa_pkg.sv
ifu_if_pipe.sv
idu.sv
idu_id_pipe.sv
regfile.sv
exu.sv
core_top.sv
tb_core_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_core_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "Result: PASSED" "$LOG"; then
    exit 0
else
    exit 1
fi
